// File: include/tiny_cpu_consts.svh
/*
  Width and depth constants for the tiny CPU.
  Included by the package and by any RTL file that sizes
  arrays or slices instruction fields.
*/

`ifndef TINY_CPU_CONSTS_SVH
`define TINY_CPU_CONSTS_SVH

// data word and instruction width
`define CPU_DATA_W 8

// program memory addressing
`define CPU_ADDR_W 4
`define CPU_DEPTH 16

// opcode and operand fields are one nibble each
`define CPU_NIBBLE_W 4

`endif

// File: rtl/tiny_cpu_pkg.sv
/*
  Shared types for the tiny CPU.
  Data, address and operand types, the opcode set and the
  register select used between control and datapath.
*/

`include "tiny_cpu_consts.svh"

package tiny_cpu_pkg;

  //////////////////////////////////////////////////
  // basic types
  typedef logic [`CPU_DATA_W-1:0] data_t;
  typedef logic [`CPU_ADDR_W-1:0] addr_t;
  typedef logic [`CPU_NIBBLE_W-1:0] nibble_t;

  //////////////////////////////////////////////////
  // opcodes, upper nibble of the instruction
  // codes 12 to 15 are not listed and decode as NOP
  typedef enum logic [`CPU_NIBBLE_W-1:0] {
    OP_NOP    = 4'd0,
    OP_LDA_LO = 4'd1,
    OP_LDA_HI = 4'd2,
    OP_LDB_LO = 4'd3,
    OP_LDB_HI = 4'd4,
    OP_LDC_LO = 4'd5,
    OP_LDC_HI = 4'd6,
    OP_ADD    = 4'd7,
    OP_SUB    = 4'd8,
    OP_MUL    = 4'd9,
    OP_OUT    = 4'd10,
    OP_IN     = 4'd11
  } opcode_e;

  // register picked by the operand of IN and OUT
  typedef enum logic [1:0] {
    SEL_A    = 2'd0,
    SEL_B    = 2'd1,
    SEL_C    = 2'd2,
    SEL_NONE = 2'd3
  } reg_sel_e;

endpackage

// File: rtl/program_ram.sv
/*
  Program store, 16 bytes.
  Written one byte per edge from outside while load_en is high;
  the byte at the program counter is read without latency.
*/

`timescale 1ns/10ps

`include "tiny_cpu_consts.svh"

module program_ram
  import tiny_cpu_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  load_en,
  input  addr_t load_addr,
  input  data_t data_in,
  input  addr_t pc,
  output data_t instr
);

  data_t mem [`CPU_DEPTH];

  //////////////////////////////////////////////////
  // external load port
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // whole program is cleared on reset
      for (int i = 0; i < `CPU_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (load_en) begin
      mem[load_addr] <= data_in;
    end
  end

  //////////////////////////////////////////////////
  // instruction fetch

  // combinational read, so a byte written at an edge is seen
  // by the decoder right after that edge
  assign instr = mem[pc];

endmodule

// File: rtl/cpu_control.sv
/*
  Program counter and instruction decode.
  Splits the fetched byte into opcode and operand and hands one
  micro-operation per cycle to the datapath. Outside of execution
  the opcode is forced to NOP and the counter holds.
*/

`timescale 1ns/10ps

`include "tiny_cpu_consts.svh"

module cpu_control
  import tiny_cpu_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     run,
  input  logic     load_en,
  input  data_t    instr,
  output addr_t    pc,
  output opcode_e  op,
  output nibble_t  operand,
  output reg_sel_e sel
);

  logic    exec;
  nibble_t op_field;

  // loading has priority over running
  assign exec = run && !load_en;

  assign op_field = instr[`CPU_DATA_W-1 -: `CPU_NIBBLE_W];
  assign operand  = instr[`CPU_NIBBLE_W-1:0];

  //////////////////////////////////////////////////
  // program counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (exec) begin
      // wraps from 15 back to 0 by width
      pc <= pc + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // opcode decode
  always_comb begin
    op = OP_NOP;
    // codes above IN are spare and stay NOP
    if (exec && op_field <= OP_IN) begin
      op = opcode_e'(op_field);
    end
  end

  // operand to register select for IN and OUT
  always_comb begin
    case (operand)
      4'd0:    sel = SEL_A;
      4'd1:    sel = SEL_B;
      4'd2:    sel = SEL_C;
      default: sel = SEL_NONE;
    endcase
  end

endmodule

// File: rtl/cpu_datapath.sv
/*
  Registers A, B and C, the ALU and the output register.
  Every update happens at the edge that consumes the opcode from
  the control block; NOP leaves all state alone.
*/

`timescale 1ns/10ps

`include "tiny_cpu_consts.svh"

module cpu_datapath
  import tiny_cpu_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  opcode_e  op,
  input  nibble_t  operand,
  input  reg_sel_e sel,
  input  data_t    data_in,
  output data_t    data_out
);

  data_t reg_a;
  data_t reg_b;
  data_t reg_c;
  data_t alu_result;
  data_t sel_value;

  //////////////////////////////////////////////////
  // ALU

  // results are truncated to 8 bits, MUL keeps the low byte
  always_comb begin
    case (op)
      OP_SUB:  alu_result = reg_a - reg_b;
      OP_MUL:  alu_result = reg_a * reg_b;
      default: alu_result = reg_a + reg_b;
    endcase
  end

  // register read for OUT
  always_comb begin
    case (sel)
      SEL_A:   sel_value = reg_a;
      SEL_B:   sel_value = reg_b;
      default: sel_value = reg_c;
    endcase
  end

  //////////////////////////////////////////////////
  // register file and output
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reg_a    <= '0;
      reg_b    <= '0;
      reg_c    <= '0;
      data_out <= '0;
    end else begin
      case (op)
        // nibble loads touch only the named half
        OP_LDA_LO: reg_a[`CPU_NIBBLE_W-1:0] <= operand;
        OP_LDA_HI: reg_a[`CPU_DATA_W-1 -: `CPU_NIBBLE_W] <= operand;
        OP_LDB_LO: reg_b[`CPU_NIBBLE_W-1:0] <= operand;
        OP_LDB_HI: reg_b[`CPU_DATA_W-1 -: `CPU_NIBBLE_W] <= operand;
        OP_LDC_LO: reg_c[`CPU_NIBBLE_W-1:0] <= operand;
        OP_LDC_HI: reg_c[`CPU_DATA_W-1 -: `CPU_NIBBLE_W] <= operand;
        OP_ADD, OP_SUB, OP_MUL: begin
          reg_c <= alu_result;
        end
        OP_IN: begin
          case (sel)
            SEL_A:   reg_a <= data_in;
            SEL_B:   reg_b <= data_in;
            SEL_C:   reg_c <= data_in;
            default: ;
          endcase
        end
        OP_OUT: begin
          // operands past C select nothing
          if (sel != SEL_NONE) begin
            data_out <= sel_value;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

// File: rtl/tiny_cpu.v
/*
  Top level of the tiny CPU.
  Joins the program store, the control block and the datapath.
  Hold load_en to write program bytes, then raise run to execute
  one instruction per clock.
*/

`timescale 1ns/10ps

module tiny_cpu (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 run,
  input  logic                 load_en,
  input  tiny_cpu_pkg::addr_t  load_addr,
  input  tiny_cpu_pkg::data_t  data_in,
  output tiny_cpu_pkg::data_t  data_out
);

  //////////////////////////////////////////////////
  // internal wiring
  tiny_cpu_pkg::addr_t    pc;
  tiny_cpu_pkg::data_t    instr;
  tiny_cpu_pkg::opcode_e  op;
  tiny_cpu_pkg::nibble_t  operand;
  tiny_cpu_pkg::reg_sel_e sel;

  // program memory loading
  program_ram program_ram_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_en   (load_en),
    .load_addr (load_addr),
    .data_in   (data_in),
    .pc        (pc),
    .instr     (instr)
  );

  // program counter and decode
  cpu_control cpu_control_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .run     (run),
    .load_en (load_en),
    .instr   (instr),
    .pc      (pc),
    .op      (op),
    .operand (operand),
    .sel     (sel)
  );

  // registers, ALU and output
  cpu_datapath cpu_datapath_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .op       (op),
    .operand  (operand),
    .sel      (sel),
    .data_in  (data_in),
    .data_out (data_out)
  );

endmodule

// File: dv/tiny_cpu_chk.sv
/*
  Concurrent checks on the tiny CPU output register.
  Bound into every tiny_cpu instance; failures go through $error
  and are counted for the testbench summary.
*/

`timescale 1ns/10ps

module tiny_cpu_chk
  import tiny_cpu_pkg::*;
(
  input logic  clk,
  input logic  rst_n,
  input logic  run,
  input logic  load_en,
  input data_t data_out
);

  int fail_count = 0;

  //////////////////////////////////////////////////
  // output register behavior

  // a reset edge clears the output
  out_cleared_by_reset: assert property (@(posedge clk) !rst_n |=> data_out == '0)
    else begin
      fail_count++;
      $error("data_out is not zero in the cycle after reset");
    end

  // no instruction executes while run is low
  out_held_when_idle: assert property (
    @(posedge clk) (rst_n && !run) |=> $stable(data_out))
    else begin
      fail_count++;
      $error("data_out changed while run was low");
    end

  // loading stalls execution
  out_held_while_loading: assert property (
    @(posedge clk) (rst_n && load_en) |=> $stable(data_out))
    else begin
      fail_count++;
      $error("data_out changed while load_en was high");
    end

endmodule

bind tiny_cpu tiny_cpu_chk tiny_cpu_chk_i (
  .clk      (clk),
  .rst_n    (rst_n),
  .run      (run),
  .load_en  (load_en),
  .data_out (data_out)
);

// File: dv/tiny_cpu_tb.sv
/*
  Testbench for the tiny CPU.
  Loads programs through the load port, runs them and compares
  data_out with a cycle model of memory, pc and registers.
  Inputs change 1 ns after each rising edge.
*/

`timescale 1ns/10ps

`include "tiny_cpu_consts.svh"

module tiny_cpu_tb
  import tiny_cpu_pkg::*;
();

  localparam int CLK_PERIOD_NS = 4;
  // summed cycle lengths of the six tests
  localparam int TEST_CYCLES = 30 + 31 + 32 + 98 + 437 + 62;

  logic  clk;
  logic  rst_n;
  logic  run;
  logic  load_en;
  addr_t load_addr;
  data_t data_in;
  data_t data_out;

  // reference model state
  data_t m_mem [`CPU_DEPTH];
  addr_t m_pc;
  data_t m_a;
  data_t m_b;
  data_t m_c;
  data_t m_out;

  data_t prog [`CPU_DEPTH];
  string test_name;
  int    errors;
  int    errors_at_start;
  int    tests_run;
  int    cycles_checked;

  tiny_cpu tiny_cpu_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .load_en   (load_en),
    .load_addr (load_addr),
    .data_in   (data_in),
    .data_out  (data_out)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD_NS / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // reference model and checks

  function automatic data_t make_instr(opcode_e code, nibble_t arg);
    return {code, arg};
  endfunction

  // one clock of the CPU from the inputs seen at the edge
  task automatic model_step();
    data_t   word;
    nibble_t code;
    nibble_t arg;
    if (!rst_n) begin
      for (int i = 0; i < `CPU_DEPTH; i++) begin
        m_mem[4'(i)] = '0;
      end
      m_pc  = '0;
      m_a   = '0;
      m_b   = '0;
      m_c   = '0;
      m_out = '0;
    end else if (load_en) begin
      m_mem[load_addr] = data_in;
    end else if (run) begin
      word = m_mem[m_pc];
      code = word[7:4];
      arg  = word[3:0];
      case (code)
        OP_LDA_LO: m_a[3:0] = arg;
        OP_LDA_HI: m_a[7:4] = arg;
        OP_LDB_LO: m_b[3:0] = arg;
        OP_LDB_HI: m_b[7:4] = arg;
        OP_LDC_LO: m_c[3:0] = arg;
        OP_LDC_HI: m_c[7:4] = arg;
        OP_ADD:    m_c = m_a + m_b;
        OP_SUB:    m_c = m_a - m_b;
        OP_MUL:    m_c = m_a * m_b;
        OP_OUT: begin
          if (arg == 4'd0) m_out = m_a;
          else if (arg == 4'd1) m_out = m_b;
          else if (arg == 4'd2) m_out = m_c;
        end
        OP_IN: begin
          if (arg == 4'd0) m_a = data_in;
          else if (arg == 4'd1) m_b = data_in;
          else if (arg == 4'd2) m_c = data_in;
        end
        default: ;
      endcase
      m_pc = m_pc + 4'd1;
    end
  endtask

  task automatic expect_out(data_t expected);
    assert (data_out === expected) else begin
      errors++;
      $display("CHECK FAILED %s expected %02h actual %02h", test_name, expected, data_out);
    end
  endtask

  // wait for an edge, step the model, compare once outputs settle
  task automatic tick();
    @(posedge clk);
    model_step();
    #1;
    cycles_checked++;
    expect_out(m_out);
  endtask

  task automatic run_cycles(int n);
    run = 1'b1;
    repeat (n) tick();
  endtask

  task automatic reset_dut(int n);
    rst_n   = 1'b0;
    run     = 1'b0;
    load_en = 1'b0;
    repeat (n) tick();
    rst_n = 1'b1;
  endtask

  task automatic clear_program();
    for (int i = 0; i < `CPU_DEPTH; i++) begin
      prog[4'(i)] = make_instr(OP_NOP, 4'd0);
    end
  endtask

  task automatic load_program();
    run     = 1'b0;
    load_en = 1'b1;
    for (int i = 0; i < `CPU_DEPTH; i++) begin
      load_addr = 4'(i);
      data_in   = prog[load_addr];
      tick();
    end
    load_en = 1'b0;
  endtask

  task automatic start_test(string name);
    test_name       = name;
    errors_at_start = errors;
    reset_dut(5);
    clear_program();
  endtask

  task automatic finish_test();
    int n;
    n = errors - errors_at_start;
    tests_run++;
    $display("test %s: %s, %0d errors", test_name, (n == 0) ? "ok" : "failed", n);
  endtask

  //////////////////////////////////////////////////
  // tests

  task automatic loads_and_out();
    data_t a;
    data_t b;
    data_t c;
    start_test("loads_and_out");
    a = 8'($urandom);
    b = 8'($urandom);
    c = 8'($urandom);
    prog[0] = make_instr(OP_LDA_LO, a[3:0]);
    prog[1] = make_instr(OP_LDA_HI, a[7:4]);
    prog[2] = make_instr(OP_LDB_LO, b[3:0]);
    prog[3] = make_instr(OP_LDB_HI, b[7:4]);
    prog[4] = make_instr(OP_LDC_LO, c[3:0]);
    prog[5] = make_instr(OP_LDC_HI, c[7:4]);
    prog[6] = make_instr(OP_OUT, 4'd0);
    prog[7] = make_instr(OP_OUT, 4'd1);
    prog[8] = make_instr(OP_OUT, 4'd2);
    load_program();
    run_cycles(7);
    expect_out(a);
    run_cycles(1);
    expect_out(b);
    run_cycles(1);
    expect_out(c);
    finish_test();
  endtask

  task automatic arithmetic_ops();
    data_t a;
    data_t b;
    data_t sum;
    data_t diff;
    data_t prod;
    start_test("arithmetic_ops");
    a = 8'($urandom);
    b = 8'($urandom);
    // expected results reduced modulo 256
    sum  = 8'((int'(a) + int'(b)) % 256);
    diff = 8'((int'(a) - int'(b) + 256) % 256);
    prod = 8'((int'(a) * int'(b)) % 256);
    prog[0] = make_instr(OP_LDA_LO, a[3:0]);
    prog[1] = make_instr(OP_LDA_HI, a[7:4]);
    prog[2] = make_instr(OP_LDB_LO, b[3:0]);
    prog[3] = make_instr(OP_LDB_HI, b[7:4]);
    prog[4] = make_instr(OP_ADD, 4'd0);
    prog[5] = make_instr(OP_OUT, 4'd2);
    prog[6] = make_instr(OP_SUB, 4'd0);
    prog[7] = make_instr(OP_OUT, 4'd2);
    prog[8] = make_instr(OP_MUL, 4'd0);
    prog[9] = make_instr(OP_OUT, 4'd2);
    load_program();
    run_cycles(6);
    expect_out(sum);
    run_cycles(2);
    expect_out(diff);
    run_cycles(2);
    expect_out(prod);
    finish_test();
  endtask

  task automatic in_capture();
    data_t vals [3];
    start_test("in_capture");
    for (int r = 0; r < 3; r++) begin
      prog[4'(2 * r)]     = make_instr(OP_IN, 4'(r));
      prog[4'(2 * r + 1)] = make_instr(OP_OUT, 4'(r));
    end
    // operands past C on both IN and OUT
    prog[6]  = make_instr(OP_IN, 4'($urandom_range(3, 15)));
    prog[7]  = make_instr(OP_OUT, 4'd0);
    prog[8]  = make_instr(OP_OUT, 4'($urandom_range(3, 15)));
    prog[9]  = make_instr(OP_OUT, 4'd1);
    prog[10] = make_instr(OP_OUT, 4'd2);
    load_program();
    for (int r = 0; r < 3; r++) begin
      vals[2'(r)] = 8'($urandom);
      data_in     = vals[2'(r)];
      run_cycles(2);
      expect_out(vals[2'(r)]);
    end
    data_in = 8'($urandom);
    run_cycles(2);
    expect_out(vals[0]);
    // output still shows A, not C, after an OUT that selects nothing
    run_cycles(1);
    expect_out(vals[0]);
    run_cycles(1);
    expect_out(vals[1]);
    run_cycles(1);
    expect_out(vals[2]);
    finish_test();
  endtask

  task automatic run_stall_wrap();
    start_test("run_stall_wrap");
    // even addresses load A with k, odd ones output it
    for (int k = 0; k < 8; k++) begin
      prog[4'(2 * k)]     = make_instr(OP_LDA_LO, 4'(k));
      prog[4'(2 * k + 1)] = make_instr(OP_OUT, 4'd0);
    end
    load_program();
    run_cycles(16);
    expect_out(8'h07);
    run_cycles(2);
    expect_out(8'h00);
    repeat (40) begin
      run = 1'($urandom_range(0, 1));
      tick();
    end
    // overwrite address 0 while running so the CPU stalls for it
    run       = 1'b1;
    load_en   = 1'b1;
    load_addr = '0;
    data_in   = make_instr(OP_LDA_LO, 4'h9);
    tick();
    load_en = 1'b0;
    for (int n = 0; n < `CPU_DEPTH && m_pc != '0; n++) begin
      tick();
    end
    run_cycles(2);
    expect_out(8'h09);
    finish_test();
  endtask

  task automatic random_programs();
    start_test("random_programs");
    repeat (2) begin
      for (int i = 0; i < `CPU_DEPTH; i++) begin
        prog[4'(i)] = 8'($urandom);
      end
      load_program();
      run = 1'b1;
      repeat (200) begin
        data_in = 8'($urandom);
        tick();
      end
    end
    finish_test();
  endtask

  task automatic reset_mid_run();
    data_t a;
    start_test("reset_mid_run");
    a = {4'($urandom), 4'h5};
    prog[0] = make_instr(OP_LDA_LO, a[3:0]);
    prog[1] = make_instr(OP_LDA_HI, a[7:4]);
    prog[2] = make_instr(OP_LDB_LO, 4'h6);
    prog[3] = make_instr(OP_OUT, 4'd0);
    load_program();
    run_cycles(4);
    expect_out(a);
    // run stays high through the reset
    rst_n = 1'b0;
    repeat (2) tick();
    expect_out(8'h00);
    rst_n = 1'b1;
    run_cycles(16);
    expect_out(8'h00);
    for (int i = 0; i < `CPU_DEPTH; i++) begin
      prog[4'(i)] = make_instr(OP_OUT, 4'(i % 3));
    end
    load_program();
    repeat (3) begin
      run_cycles(1);
      expect_out(8'h00);
    end
    finish_test();
  endtask

  //////////////////////////////////////////////////
  // main sequence and watchdog

  initial begin
    int total;
    rst_n     = 1'b0;
    run       = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    data_in   = '0;
    errors         = 0;
    tests_run      = 0;
    cycles_checked = 0;
    void'($urandom(32'h32e1_6118));
    loads_and_out();
    arithmetic_ops();
    in_capture();
    run_stall_wrap();
    random_programs();
    reset_mid_run();
    total = errors + tiny_cpu_i.tiny_cpu_chk_i.fail_count;
    $display("%0d tests, %0d cycles checked, %0d check errors, %0d assertion errors",
             tests_run, cycles_checked, errors, tiny_cpu_i.tiny_cpu_chk_i.fail_count);
    if (total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(2 * TEST_CYCLES * CLK_PERIOD_NS);
    $display("timeout: the tests did not finish within %0d ns",
             2 * TEST_CYCLES * CLK_PERIOD_NS);
    $display("Test failures found");
    $finish;
  end

endmodule

// File: tiny_cpu.f
+incdir+include
rtl/tiny_cpu_pkg.sv
rtl/program_ram.sv
rtl/cpu_control.sv
rtl/cpu_datapath.sv
rtl/tiny_cpu.v
dv/tiny_cpu_chk.sv
dv/tiny_cpu_tb.sv

// File: Makefile
# Verilator lint and simulation for the tiny CPU

TOP := tiny_cpu_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f tiny_cpu.f

# pass or fail is read from the simulation log
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tiny_cpu.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	@grep -q "All tests passed!" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
